/* hw/export_pkg.sv */
`default_nettype none

package export_pkg;

  // display geometry with one 4-bit gray level per pixel
  localparam int DISPLAY_WIDTH = 32;
  localparam int DISPLAY_HEIGHT = 32;
  localparam int H_BITS = 5; // column part of the address
  localparam int ADDR_BITS = 10; // row in the upper bits, column in the lower

  // the start frame is 50 bytes of 0xff
  localparam int START_FRAME_DIBITS = 4*50;
  localparam int ROW_ID_DIBITS = 16; // 32-bit row number

  // the framing around every payload, in dibits on the wire
  localparam int PREAMBLE_DIBITS = 28;
  localparam int SFD_DIBITS = 4;
  localparam int FCS_DIBITS = 16;
  localparam int GAP_DIBITS = 48; // 96 bit times of idle

  // reflected form of the ethernet crc-32 polynomial
  localparam logic [31:0] CRC32_POLY = 32'hedb88320;

  typedef logic [ADDR_BITS-1:0] pix_addr_t;

  // the writer and the memory see one gray level, the exporter shifts it out as two dibits
  typedef union packed {
    logic [3:0] gray;
    struct packed {
      logic [1:0] hi;
      logic [1:0] lo;
    } dibits;
  } pixel_t;

  typedef struct packed {
    logic [1:0] data;
    logic       last; // set on the final payload dibit of a frame
  } dibit_t;

endpackage

`default_nettype wire

/* hw/frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
  input  wire logic                  clk_in,
  input  wire logic                  wr_en,
  input  wire export_pkg::pix_addr_t wr_addr,
  input  wire export_pkg::pixel_t    wr_pixel,
  input  wire export_pkg::pix_addr_t rd_addr,
  output export_pkg::pixel_t         rd_pixel
);

  import export_pkg::*;

  // one entry per pixel, row major
  logic [3:0] mem [DISPLAY_WIDTH*DISPLAY_HEIGHT];

  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_pixel.gray;
    end
  end

  // a read of the address being written returns the old level
  always_ff @(posedge clk_in) begin
    rd_pixel.gray <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* hw/ether_crc32.sv */
`timescale 1ns/1ps
`default_nettype none

module ether_crc32 (
  input  wire logic       clk_in,
  input  wire logic       rst_in,
  input  wire logic       clear,
  input  wire logic       advance,
  input  wire logic [1:0] dibit,
  output logic [31:0]     crc_value
);

  import export_pkg::*;

  logic [31:0] crc_q;
  logic [31:0] crc_next;

  // one bit of the reflected shift register
  function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic data_bit);
    logic feedback;
    feedback = crc[0] ^ data_bit;
    crc_step = (crc >> 1) ^ (feedback ? CRC32_POLY : 32'h0);
  endfunction

  always_comb begin
    crc_next = crc_step(crc_step(crc_q, dibit[0]), dibit[1]); // low bit goes first on the wire
  end

  always_ff @(posedge clk_in) begin
    if (rst_in || clear) begin
      crc_q <= '1;
    end else if (advance) begin
      crc_q <= crc_next;
    end
  end

  assign crc_value = ~crc_q; // already in transmit order, lsb first

endmodule

`default_nettype wire

/* hw/ether_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module ether_tx (
  input  wire logic               clk_in,
  input  wire logic               rst_in,
  input  wire logic               trigger,
  input  wire export_pkg::dibit_t tx_dibit,
  output logic                    tx_ready,
  output logic                    data_ready,
  output logic                    eth_txen,
  output logic [1:0]              eth_txd
);

  import export_pkg::*;

  typedef enum logic [2:0] {idle, preamble, payload, fcs, gap} tx_state_t;

  tx_state_t   state;
  logic [5:0]  cnt; // shared by preamble, fcs and gap
  logic [31:0] fcs_q;
  logic [31:0] fcs_word;

  logic        crc_clear;
  logic        crc_advance;
  logic [1:0]  crc_dibit;
  logic [31:0] crc_value;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= idle;
      cnt <= '0;
    end else begin
      case (state)
        idle: begin
          if (trigger) begin
            state <= preamble;
            cnt <= '0;
          end
        end
        preamble: begin
          if (cnt == PREAMBLE_DIBITS + SFD_DIBITS - 1) begin
            state <= payload;
            cnt <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        payload: begin
          if (tx_dibit.last) begin
            state <= fcs;
            cnt <= '0;
          end
        end
        fcs: begin
          if (cnt == FCS_DIBITS - 1) begin
            state <= gap;
            cnt <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        gap: begin
          if (cnt == GAP_DIBITS - 1) begin
            state <= idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // the crc settles on the edge that leaves payload, so the first fcs dibit
  // comes straight from the checker and the rest from the shift register
  assign fcs_word = (cnt == 0) ? crc_value : fcs_q;

  always_ff @(posedge clk_in) begin
    if (state == fcs) begin
      fcs_q <= fcs_word >> 2;
    end
  end

  assign tx_ready = state == idle;
  assign data_ready = state == payload;
  assign eth_txen = state == preamble || state == payload || state == fcs;

  always_comb begin
    case (state)
      preamble: eth_txd = (cnt == PREAMBLE_DIBITS + SFD_DIBITS - 1) ? 2'b11 : 2'b01;
      payload: eth_txd = tx_dibit.data;
      fcs: eth_txd = fcs_word[1:0];
      default: eth_txd = 2'b00;
    endcase
  end

  assign crc_clear = state == preamble; // preset before the first payload dibit
  assign crc_advance = data_ready;
  assign crc_dibit = tx_dibit.data;

  ether_crc32 u_crc (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .clear    (crc_clear),
    .advance  (crc_advance),
    .dibit    (crc_dibit),
    .crc_value(crc_value)
  );

  trigger_only_when_ready: assert property (@(posedge clk_in) disable iff (rst_in)
    trigger |-> tx_ready);

  data_only_on_wire: assert property (@(posedge clk_in) disable iff (rst_in)
    data_ready |-> eth_txen);

  payload_ends_on_last: assert property (@(posedge clk_in) disable iff (rst_in)
    $fell(data_ready) |-> $past(tx_dibit.last));

endmodule

`default_nettype wire

/* hw/ether_export.sv */
`timescale 1ns/1ps
`default_nettype none

module ether_export (
  input  wire logic                  clk_in,
  input  wire logic                  rst_in,
  input  wire logic                  export_trigger,
  output logic                       export_ready,
  output export_pkg::pix_addr_t      rd_addr,
  input  wire export_pkg::pixel_t    rd_pixel,
  output logic                       tx_trigger,
  output export_pkg::dibit_t         tx_dibit,
  input  wire logic                  tx_ready,
  input  wire logic                  data_ready
);

  import export_pkg::*;

  typedef enum logic [2:0] {ready, start_frame, frame_check, start_row, pixels} exp_state_t;

  exp_state_t                           state;
  logic [$clog2(START_FRAME_DIBITS)-1:0] cnt;
  logic [ADDR_BITS-H_BITS-1:0]          row;
  logic [2*ROW_ID_DIBITS-1:0]           row_word;
  logic [H_BITS-1:0]                    col;
  logic [H_BITS-1:0]                    next_col;
  logic                                 pixel_last;

  assign export_ready = state == ready && tx_ready;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= ready;
      cnt <= '0;
      row <= '0;
    end else begin
      case (state)
        ready: begin
          if (tx_trigger) begin
            state <= start_frame;
            cnt <= '0;
            row <= '0;
          end
        end
        start_frame: begin
          if (data_ready) begin
            if (tx_dibit.last) begin
              state <= frame_check;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        frame_check: begin
          if (tx_ready) begin // the trigger goes out in this same cycle
            state <= start_row;
            cnt <= '0;
          end
        end
        start_row: begin
          if (data_ready) begin
            if (cnt == ROW_ID_DIBITS - 1) begin
              state <= pixels;
              cnt <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        pixels: begin
          if (data_ready) begin
            if (pixel_last) begin
              if (row == DISPLAY_HEIGHT - 1) begin
                state <= ready;
              end else begin
                state <= frame_check;
                row <= row + 1'b1;
              end
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        default: state <= ready;
      endcase
    end
  end

  assign row_word = (2*ROW_ID_DIBITS)'(row);
  assign col = cnt[H_BITS:1]; // two dibits per pixel
  assign pixel_last = cnt == 2*DISPLAY_WIDTH - 1;

  // the memory answers one cycle late, so ask for the pixel of the next dibit
  assign next_col = pixel_last ? col : col + H_BITS'(cnt[0]);
  assign rd_addr = (state == pixels) ? {row, next_col} : {row, {H_BITS{1'b0}}};

  always_comb begin
    tx_trigger = 1'b0;
    tx_dibit = '0;
    case (state)
      ready: tx_trigger = export_trigger && tx_ready;
      start_frame: begin
        tx_dibit.data = 2'b11;
        tx_dibit.last = cnt == START_FRAME_DIBITS - 1;
      end
      frame_check: tx_trigger = tx_ready;
      start_row: tx_dibit.data = row_word[{cnt[3:0], 1'b0} +: 2]; // least significant dibit first
      pixels: begin
        tx_dibit.data = cnt[0] ? rd_pixel.dibits.lo : rd_pixel.dibits.hi;
        tx_dibit.last = pixel_last;
      end
      default: tx_dibit = '0;
    endcase
  end

  // the pixel on the bus was asked for one cycle earlier, at this row and column
  rd_addr_in_image: assert property (@(posedge clk_in) disable iff (rst_in)
    state == pixels |-> $past(rd_addr) == {row, col});

endmodule

`default_nettype wire

/* hw/export_top.sv */
`timescale 1ns/1ps
`default_nettype none

module export_top (
  input  wire logic                  clk_in,
  input  wire logic                  rst_in,
  input  wire logic                  wr_en,
  input  wire export_pkg::pix_addr_t wr_addr,
  input  wire export_pkg::pixel_t    wr_pixel,
  input  wire logic                  export_trigger,
  output logic                       export_ready,
  output logic                       eth_txen,
  output logic [1:0]                 eth_txd
);

  import export_pkg::*;

  pix_addr_t rd_addr;
  pixel_t    rd_pixel;
  logic      tx_trigger;
  dibit_t    tx_dibit;
  logic      tx_ready;
  logic      data_ready;

  frame_buffer u_frame_buffer (
    .clk_in  (clk_in),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_pixel(wr_pixel),
    .rd_addr (rd_addr),
    .rd_pixel(rd_pixel)
  );

  ether_export u_export (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .export_trigger(export_trigger),
    .export_ready  (export_ready),
    .rd_addr       (rd_addr),
    .rd_pixel      (rd_pixel),
    .tx_trigger    (tx_trigger),
    .tx_dibit      (tx_dibit),
    .tx_ready      (tx_ready),
    .data_ready    (data_ready)
  );

  ether_tx u_tx (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .trigger   (tx_trigger),
    .tx_dibit  (tx_dibit),
    .tx_ready  (tx_ready),
    .data_ready(data_ready),
    .eth_txen  (eth_txen),
    .eth_txd   (eth_txd)
  );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_in,
  output logic rst_in
);

  localparam int RESET_CYCLES = 16;

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in; // 100 ns period
  end

  // reset covers the first rising edges and drops on a falling edge
  initial begin
    rst_in = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
  end

endmodule

`default_nettype wire

/* sim/tb_export_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_export_top;

  import export_pkg::*;

  localparam int IMAGES = 2;
  localparam int PIXELS = DISPLAY_WIDTH*DISPLAY_HEIGHT;
  localparam int FRAMES_PER_EXPORT = DISPLAY_HEIGHT + 1;
  localparam int TIMEOUT_CYCLES = IMAGES*FRAMES_PER_EXPORT*400 + 2000;
  localparam logic [31:0] FCS_POLY = 32'hedb88320; // reflected 802.3 polynomial
  localparam logic [15:0] LFSR_SEED = 16'd99;

  logic       clk_in;
  logic       rst_in;
  logic       wr_en;
  pix_addr_t  wr_addr;
  pixel_t     wr_pixel;
  logic       export_trigger;
  logic       export_ready;
  logic       eth_txen;
  logic [1:0] eth_txd;

  logic [3:0]  model [PIXELS]; // what the DUT memory should hold
  logic [15:0] lfsr_state;
  logic [1:0]  wire_q [$]; // dibits of the frame now on the wire
  logic        txen_prev = 1'b0;
  logic        busy = 1'b0;
  int          errors = 0;
  int          frames_seen = 0;
  int          exports_started = 0;
  int          idle_run = 0;
  int          cycles = 0;

  tb_clock u_clock (
    .clk_in(clk_in),
    .rst_in(rst_in)
  );

  export_top u_dut (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_pixel      (wr_pixel),
    .export_trigger(export_trigger),
    .export_ready  (export_ready),
    .eth_txen      (eth_txen),
    .eth_txd       (eth_txd)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    lfsr_step = {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task random_bits(input int n, output logic [31:0] value);
    value = '0;
    repeat (n) begin
      lfsr_state = lfsr_step(lfsr_state); // one step for every bit taken
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  task write_image();
    logic [31:0] value;
    int          addr;
    for (addr = 0; addr < PIXELS; addr++) begin
      random_bits(4, value);
      @(negedge clk_in);
      wr_en = 1'b1;
      wr_addr = pix_addr_t'(addr);
      wr_pixel.gray = value[3:0];
      model[addr] = value[3:0];
    end
    @(negedge clk_in);
    wr_en = 1'b0;
  endtask

  // builds the whole expected frame and compares it with the collected dibits
  task automatic check_frame(input int frame_no);
    logic [1:0]  exp_q [$];
    logic [31:0] crc;
    logic [31:0] row_id;
    logic        feedback;
    int          row;
    int          payload_start;
    int          i;
    int          j;
    crc = '1;
    repeat (PREAMBLE_DIBITS) exp_q.push_back(2'b01);
    for (i = 0; i < SFD_DIBITS; i++) begin
      exp_q.push_back((i == SFD_DIBITS - 1) ? 2'b11 : 2'b01);
    end
    payload_start = exp_q.size();
    if (frame_no % FRAMES_PER_EXPORT == 0) begin
      repeat (START_FRAME_DIBITS) exp_q.push_back(2'b11);
    end else begin
      row = frame_no % FRAMES_PER_EXPORT - 1;
      row_id = row;
      for (i = 0; i < ROW_ID_DIBITS; i++) begin
        exp_q.push_back(row_id[2*i +: 2]);
      end
      for (i = 0; i < DISPLAY_WIDTH; i++) begin
        exp_q.push_back(model[row*DISPLAY_WIDTH + i][3:2]);
        exp_q.push_back(model[row*DISPLAY_WIDTH + i][1:0]);
      end
    end
    // the fcs covers the payload only, low bit of each dibit first
    for (i = payload_start; i < exp_q.size(); i++) begin
      for (j = 0; j < 2; j++) begin
        feedback = crc[0] ^ exp_q[i][j];
        crc = crc >> 1;
        if (feedback) crc = crc ^ FCS_POLY;
      end
    end
    crc = ~crc;
    for (i = 0; i < FCS_DIBITS; i++) begin
      exp_q.push_back(crc[2*i +: 2]);
    end
    assert (wire_q.size() == exp_q.size()) else begin
      errors++;
      $display("frame %0d has %0d dibits on the wire where %0d were expected",
               frame_no, wire_q.size(), exp_q.size());
    end
    for (i = 0; i < exp_q.size() && i < wire_q.size(); i++) begin
      assert (wire_q[i] === exp_q[i]) else begin
        errors++;
        $display("[FAIL] eth_txd frame %0d dibit %0d: got %h, expected %h",
                 frame_no, i, wire_q[i], exp_q[i]);
      end
    end
  endtask

  // collects frames, checks the gap and the export_ready window
  always @(posedge clk_in) begin
    if (!rst_in) begin
      if (eth_txen) begin
        if (!txen_prev && frames_seen > 0) begin
          assert (idle_run >= GAP_DIBITS) else begin
            errors++;
            $display("only %0d idle cycles before frame %0d", idle_run, frames_seen);
          end
        end
        wire_q.push_back(eth_txd);
      end else begin
        if (txen_prev) begin
          check_frame(frames_seen);
          frames_seen++;
          wire_q.delete();
          idle_run = 0;
        end
        idle_run++;
      end
      if (busy && export_ready) begin
        assert (frames_seen == exports_started*FRAMES_PER_EXPORT) else begin
          errors++;
          $display("[FAIL] frames at export_ready: got %h, expected %h",
                   frames_seen, exports_started*FRAMES_PER_EXPORT);
        end
        busy = 1'b0;
      end
      if (!busy && export_ready && export_trigger) begin
        exports_started++;
        busy = 1'b1;
      end
      txen_prev = eth_txen;
    end
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run hung, export not finished after %0d cycles", cycles);
      $display("errors %0d, frames checked %0d, exports %0d",
               errors + 1, frames_seen, exports_started);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    logic [31:0] delay;
    int          img;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_pixel = '0;
    export_trigger = 1'b0;
    lfsr_state = LFSR_SEED;
    wait (rst_in === 1'b0);
    @(negedge clk_in);
    assert (eth_txen === 1'b0) else begin
      errors++;
      $display("[FAIL] eth_txen after reset: got %h, expected %h", eth_txen, 1'b0);
    end
    assert (export_ready === 1'b1) else begin
      errors++;
      $display("[FAIL] export_ready after reset: got %h, expected %h", export_ready, 1'b1);
    end
    for (img = 0; img < IMAGES; img++) begin
      write_image();
      @(negedge clk_in);
      export_trigger = 1'b1;
      @(negedge clk_in);
      export_trigger = 1'b0;
      // a second trigger in the middle of the export must be ignored
      random_bits(8, delay);
      repeat (300 + delay) @(negedge clk_in);
      assert (export_ready === 1'b0) else begin
        errors++;
        $display("[FAIL] export_ready during export: got %h, expected %h", export_ready, 1'b0);
      end
      export_trigger = 1'b1;
      repeat (40) @(negedge clk_in);
      export_trigger = 1'b0;
      do @(negedge clk_in); while (export_ready !== 1'b1);
    end
    repeat (4) @(negedge clk_in);
    assert (exports_started == IMAGES) else begin
      errors++;
      $display("[FAIL] accepted triggers: got %h, expected %h", exports_started, IMAGES);
    end
    assert (frames_seen == IMAGES*FRAMES_PER_EXPORT) else begin
      errors++;
      $display("[FAIL] frame count: got %h, expected %h",
               frames_seen, IMAGES*FRAMES_PER_EXPORT);
    end
    $display("errors %0d, frames checked %0d, exports %0d", errors, frames_seen, exports_started);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
hw/export_pkg.sv
hw/frame_buffer.sv
hw/ether_crc32.sv
hw/ether_tx.sv
hw/ether_export.sv
hw/export_top.sv
sim/tb_clock.sv
sim/tb_export_top.sv

/* Bender.yml */
package:
  name: frame_export

sources:
  - hw/export_pkg.sv
  - hw/frame_buffer.sv
  - hw/ether_crc32.sv
  - hw/ether_tx.sv
  - hw/ether_export.sv
  - hw/export_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_export_top.sv
